// ==== src/oooConsts.svh ====
`ifndef OOO_CONSTS_SVH
`define OOO_CONSTS_SVH

// datapath width
`define XLEN 32

// physical register space, p0 is the hard zero register
`define PREG_COUNT 128
`define PREG_BITS 7

// window sizes, both powers of two so the indices wrap naturally
`define RS_DEPTH 16 // reservation station entries
`define ROB_DEPTH 16 // reorder buffer entries

// data memory, word addressed by byte address bits 9:2
`define DMEM_WORDS 256

`endif

// ==== src/isaPkg.sv ====
`default_nettype none
`include "oooConsts.svh"

package isaPkg;

	typedef logic [`XLEN-1:0] wordT; // data word
	typedef logic [`PREG_BITS-1:0] pregT; // physical register number

	// encoding matches the decode stage ALUOp field
	typedef enum logic [1:0] {
		ALU_ADD = 2'b00,
		ALU_SUB = 2'b01,
		ALU_OR = 2'b10,
		ALU_AND = 2'b11
	} aluOpT;

	// which execution unit takes the instruction
	typedef enum logic {
		FU_ALU = 1'b0,
		FU_MEM = 1'b1 // loads and stores
	} fuT;

endpackage

`default_nettype wire

// ==== src/windowPkg.sv ====
`default_nettype none
`include "oooConsts.svh"

package windowPkg;
	import isaPkg::*;

	typedef logic [$clog2(`ROB_DEPTH)-1:0] robIdxT; // reorder buffer slot
	typedef logic [$clog2(`RS_DEPTH)-1:0] rsIdxT; // reservation station slot

	// one waiting instruction
	typedef struct packed {
		logic inUse; // slot holds an instruction
		fuT fu; // target unit
		aluOpT aluOp; // add/sub/or/and
		logic isStore; // store, no register result
		logic aluSrc; // 1: second operand is imm
		robIdxT rob; // owning rob slot
		pregT rd; // destination
		pregT rs1; // source tags
		pregT rs2;
		logic rs1Ready; // operand captured
		logic rs2Ready;
		wordT rs1Val; // operand values
		wordT rs2Val;
		wordT imm; // immediate, also address offset
	} rsEntryT;

	// one in-flight instruction in program order
	typedef struct packed {
		logic valid; // slot allocated
		logic complete; // result is back
		logic isStore; // write memory at retire
		pregT dest; // new mapping
		pregT oldDest; // mapping to free at retire
		wordT pc; // reported at retire
		wordT result; // register value
		wordT stAddr; // store address
		wordT stData; // store data
	} robEntryT;

endpackage

`default_nettype wire

// ==== src/physRegFile.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "oooConsts.svh"

module physRegFile import isaPkg::*; (
	input wire logic clk,
	input wire logic rst,
	input wire pregT rdAddr1,
	input wire pregT rdAddr2,
	output wordT rdData1,
	output wordT rdData2,
	output logic rdReady1,
	output logic rdReady2,
	input wire logic allocValid,
	input wire pregT allocRd,
	input wire logic aluWbValid,
	input wire pregT aluWbRd,
	input wire wordT aluWbData,
	input wire logic memWbValid,
	input wire pregT memWbRd,
	input wire wordT memWbData
);

	wordT regs [`PREG_COUNT]; // value array
	logic [`PREG_COUNT-1:0] ready; // one ready bit per preg

	initial begin
		for (int i = 0; i < `PREG_COUNT; i++) begin
			regs[i] = '0; // registers start at zero
		end
	end

	// read with same-cycle completions passed through
	function automatic wordT readData(input pregT addr);
		wordT d;
		d = regs[addr];
		if (memWbValid && memWbRd == addr) d = memWbData;
		if (aluWbValid && aluWbRd == addr) d = aluWbData;
		if (addr == '0) d = '0; // p0 always reads zero
		return d;
	endfunction

	function automatic logic readReady(input pregT addr);
		return ready[addr] || (aluWbValid && aluWbRd == addr) ||
			(memWbValid && memWbRd == addr);
	endfunction

	always_comb begin
		rdData1 = readData(rdAddr1);
		rdData2 = readData(rdAddr2);
		rdReady1 = readReady(rdAddr1);
		rdReady2 = readReady(rdAddr2);
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			ready <= '1; // all mappings valid after reset
		end else begin
			if (allocValid && allocRd != '0) ready[allocRd] <= 1'b0; // new dest pending
			if (aluWbValid && aluWbRd != '0) ready[aluWbRd] <= 1'b1;
			if (memWbValid && memWbRd != '0) ready[memWbRd] <= 1'b1;
		end
	end

	always @(posedge clk) begin
		if (aluWbValid && aluWbRd != '0) regs[aluWbRd] <= aluWbData; // p0 never written
		if (memWbValid && memWbRd != '0) regs[memWbRd] <= memWbData;
	end

endmodule

`default_nettype wire

// ==== src/reservationStation.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "oooConsts.svh"

module reservationStation import isaPkg::*, windowPkg::*; (
	input wire logic clk,
	input wire logic rst,
	input wire logic dispFire,
	input wire pregT dispRs1,
	input wire pregT dispRs2,
	input wire pregT dispRd,
	input wire wordT dispImm,
	input wire logic dispAluSrc,
	input wire aluOpT dispAluOp,
	input wire fuT dispFu,
	input wire logic dispIsStore,
	input wire robIdxT dispRob,
	input wire wordT src1Data,
	input wire wordT src2Data,
	input wire logic src1Ready,
	input wire logic src2Ready,
	output logic rsFree,
	input wire logic aluWbValid,
	input wire pregT aluWbRd,
	input wire wordT aluWbData,
	input wire logic memWbValid,
	input wire pregT memWbRd,
	input wire wordT memWbData,
	output logic aluIssue,
	output rsEntryT aluIssueEntry,
	output logic memIssue,
	output rsEntryT memIssueEntry
);

	rsEntryT entries [`RS_DEPTH]; // the window
	rsIdxT freeIdx; // lowest empty slot
	rsIdxT aluIdx; // lowest ready alu slot
	rsIdxT memIdx; // lowest ready mem slot

	// tag match against one broadcast, p0 never wakes anyone
	function automatic logic wakes(input pregT src, input logic wbValid, input pregT wbRd);
		return wbValid && wbRd != '0 && src == wbRd;
	endfunction

	// scan downward so the lowest index is left standing
	always_comb begin
		rsFree = 1'b0;
		freeIdx = '0;
		for (int i = `RS_DEPTH - 1; i >= 0; i--) begin
			if (!entries[i].inUse) begin
				rsFree = 1'b1;
				freeIdx = rsIdxT'(i);
			end
		end
	end

	always_comb begin
		aluIssue = 1'b0;
		aluIdx = '0;
		memIssue = 1'b0;
		memIdx = '0;
		for (int i = `RS_DEPTH - 1; i >= 0; i--) begin
			if (entries[i].inUse && entries[i].rs1Ready && entries[i].rs2Ready) begin
				if (entries[i].fu == FU_ALU) begin
					aluIssue = 1'b1;
					aluIdx = rsIdxT'(i);
				end else begin
					memIssue = 1'b1;
					memIdx = rsIdxT'(i);
				end
			end
		end
	end

	assign aluIssueEntry = entries[aluIdx]; // taken by the unit at the edge
	assign memIssueEntry = entries[memIdx];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `RS_DEPTH; i++) begin
				entries[i].inUse <= 1'b0;
			end
		end else begin
			// wakeup, value captured straight off the broadcast
			for (int i = 0; i < `RS_DEPTH; i++) begin
				if (entries[i].inUse && !entries[i].rs1Ready) begin
					if (wakes(entries[i].rs1, aluWbValid, aluWbRd)) begin
						entries[i].rs1Val <= aluWbData;
						entries[i].rs1Ready <= 1'b1;
					end else if (wakes(entries[i].rs1, memWbValid, memWbRd)) begin
						entries[i].rs1Val <= memWbData;
						entries[i].rs1Ready <= 1'b1;
					end
				end
				if (entries[i].inUse && !entries[i].rs2Ready) begin
					if (wakes(entries[i].rs2, aluWbValid, aluWbRd)) begin
						entries[i].rs2Val <= aluWbData;
						entries[i].rs2Ready <= 1'b1;
					end else if (wakes(entries[i].rs2, memWbValid, memWbRd)) begin
						entries[i].rs2Val <= memWbData;
						entries[i].rs2Ready <= 1'b1;
					end
				end
			end
			if (aluIssue) entries[aluIdx].inUse <= 1'b0; // slot handed to alu
			if (memIssue) entries[memIdx].inUse <= 1'b0;
			if (dispFire) begin
				entries[freeIdx] <= '{
					inUse: 1'b1,
					fu: dispFu,
					aluOp: dispAluOp,
					isStore: dispIsStore,
					aluSrc: dispAluSrc,
					rob: dispRob,
					rd: dispRd,
					rs1: dispRs1,
					rs2: dispRs2,
					rs1Ready: src1Ready, // regfile read already sees this cycle's wb
					rs2Ready: src2Ready,
					rs1Val: src1Data,
					rs2Val: src2Data,
					imm: dispImm
				};
			end
		end
	end

endmodule

`default_nettype wire

// ==== src/reorderBuffer.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "oooConsts.svh"

module reorderBuffer import isaPkg::*, windowPkg::*; (
	input wire logic clk,
	input wire logic rst,
	input wire logic dispFire,
	input wire pregT dispRd,
	input wire pregT dispOldRd,
	input wire wordT dispPc,
	input wire logic dispIsStore,
	output robIdxT allocIdx,
	output logic robFree,
	input wire logic aluWbValid,
	input wire robIdxT aluWbRob,
	input wire wordT aluWbData,
	input wire logic memWbValid,
	input wire robIdxT memWbRob,
	input wire wordT memWbData,
	input wire logic memWbStore,
	input wire wordT memWbAddr,
	input wire wordT memWbStoreData,
	output logic retireValid,
	output wordT retirePc,
	output pregT retireDest,
	output wordT retireValue,
	output pregT retireOldDest,
	output logic retireIsStore,
	output wordT storeAddr,
	output wordT storeData
);

	localparam int CW = $clog2(`ROB_DEPTH) + 1; // count needs room for full

	robEntryT entries [`ROB_DEPTH];
	robIdxT head; // oldest, next to retire
	robIdxT tail; // next free slot
	logic [CW-1:0] count; // occupied slots
	robEntryT headEntry;

	assign headEntry = entries[head];
	assign allocIdx = tail;
	assign robFree = count != CW'(`ROB_DEPTH);

	// retire straight from the head, one per cycle
	assign retireValid = headEntry.valid && headEntry.complete;
	assign retirePc = headEntry.pc;
	assign retireDest = headEntry.dest;
	assign retireValue = headEntry.result;
	assign retireOldDest = headEntry.oldDest; // back to the free list
	assign retireIsStore = retireValid && headEntry.isStore; // doubles as dmem write strobe
	assign storeAddr = headEntry.stAddr;
	assign storeData = headEntry.stData;

	always_ff @(posedge clk) begin
		if (rst) begin
			head <= '0;
			tail <= '0;
			count <= '0;
			for (int i = 0; i < `ROB_DEPTH; i++) begin
				entries[i].valid <= 1'b0;
				entries[i].complete <= 1'b0;
			end
		end else begin
			if (dispFire) begin
				entries[tail] <= '{
					valid: 1'b1,
					complete: 1'b0,
					isStore: dispIsStore,
					dest: dispRd,
					oldDest: dispOldRd,
					pc: dispPc,
					result: '0,
					stAddr: '0,
					stData: '0
				};
				tail <= tail + 1'b1; // wraps at depth
			end
			if (aluWbValid) begin
				entries[aluWbRob].result <= aluWbData;
				entries[aluWbRob].complete <= 1'b1;
			end
			if (memWbValid) begin
				entries[memWbRob].result <= memWbData; // zero for a store
				entries[memWbRob].complete <= 1'b1;
				if (memWbStore) begin
					entries[memWbRob].stAddr <= memWbAddr;
					entries[memWbRob].stData <= memWbStoreData;
				end
			end
			if (retireValid) begin
				entries[head].valid <= 1'b0;
				head <= head + 1'b1;
			end
			count <= count + CW'(dispFire) - CW'(retireValid);
		end
	end

endmodule

`default_nettype wire

// ==== src/aluUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module aluUnit import isaPkg::*, windowPkg::*; (
	input wire logic clk,
	input wire logic rst,
	input wire logic issue,
	input wire rsEntryT issueEntry,
	output logic wbValid,
	output pregT wbRd,
	output robIdxT wbRob,
	output wordT wbData
);

	logic vld; // issue register occupied
	rsEntryT held; // issued instruction
	wordT opB; // rs2 or imm

	always_ff @(posedge clk) begin
		if (rst) vld <= 1'b0;
		else vld <= issue; // one cycle per instruction
	end

	always_ff @(posedge clk) begin
		if (issue) held <= issueEntry;
	end

	always_comb begin
		opB = held.aluSrc ? held.imm : held.rs2Val;
		case (held.aluOp)
			ALU_ADD: wbData = held.rs1Val + opB;
			ALU_SUB: wbData = held.rs1Val - opB;
			ALU_OR: wbData = held.rs1Val | opB;
			default: wbData = held.rs1Val & opB; // ALU_AND
		endcase
	end

	assign wbValid = vld; // broadcast lasts the cycle after issue
	assign wbRd = held.rd;
	assign wbRob = held.rob;

endmodule

`default_nettype wire

// ==== src/memUnit.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "oooConsts.svh"

module memUnit import isaPkg::*, windowPkg::*; (
	input wire logic clk,
	input wire logic rst,
	input wire logic issue,
	input wire rsEntryT issueEntry,
	output logic wbValid,
	output pregT wbRd,
	output robIdxT wbRob,
	output wordT wbData,
	output logic wbStore,
	output wordT wbAddr,
	output wordT wbStoreData,
	input wire logic storeWrite,
	input wire wordT storeAddr,
	input wire wordT storeData
);

	localparam int AW = $clog2(`DMEM_WORDS); // word index bits

	wordT dmem [`DMEM_WORDS];
	logic vld;
	rsEntryT held;
	wordT addr; // effective address

	initial begin
		for (int i = 0; i < `DMEM_WORDS; i++) begin
			dmem[i] = '0;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) vld <= 1'b0;
		else vld <= issue;
	end

	always_ff @(posedge clk) begin
		if (issue) held <= issueEntry;
	end

	assign addr = held.rs1Val + held.imm; // base plus offset

	assign wbValid = vld;
	assign wbRob = held.rob;
	assign wbStore = held.isStore;
	assign wbRd = held.isStore ? '0 : held.rd; // store writes no register
	assign wbData = held.isStore ? '0 : dmem[addr[AW+1:2]]; // load reads at execute
	assign wbAddr = addr;
	assign wbStoreData = held.rs2Val; // parked in the rob until retire

	// memory only changes when a store leaves the rob
	always @(posedge clk) begin
		if (storeWrite) dmem[storeAddr[AW+1:2]] <= storeData;
	end

endmodule

`default_nettype wire

// ==== src/oooCore.sv ====
`timescale 1ns/1ps
`default_nettype none

module oooCore import isaPkg::*, windowPkg::*; (
	input wire logic clk,
	input wire logic rst,
	input wire logic dispValid,
	input wire wordT dispPc,
	input wire pregT dispRd,
	input wire pregT dispOldRd,
	input wire pregT dispRs1,
	input wire pregT dispRs2,
	input wire wordT dispImm,
	input wire logic dispAluSrc,
	input wire aluOpT dispAluOp,
	input wire logic dispIsLoad,
	input wire logic dispIsStore,
	output logic dispReady,
	output logic retireValid,
	output wordT retirePc,
	output pregT retireDest,
	output wordT retireValue,
	output pregT retireOldDest,
	output logic retireIsStore,
	output wordT storeAddr,
	output wordT storeData
);

	logic dispFire, robFree, rsFree;
	fuT dispFu;
	robIdxT allocIdx;
	wordT src1Data, src2Data;
	logic src1Ready, src2Ready;
	logic aluIssue, memIssue;
	rsEntryT aluIssueEntry, memIssueEntry;
	logic aluWbValid, memWbValid, memWbStore;
	pregT aluWbRd, memWbRd;
	robIdxT aluWbRob, memWbRob;
	wordT aluWbData, memWbData, memWbAddr, memWbStoreData;

	assign dispReady = robFree && rsFree; // room in both windows
	assign dispFire = dispValid && dispReady;
	assign dispFu = (dispIsLoad || dispIsStore) ? FU_MEM : FU_ALU;

	physRegFile prf (
		.clk(clk), .rst(rst),
		.rdAddr1(dispRs1), .rdAddr2(dispRs2),
		.rdData1(src1Data), .rdData2(src2Data),
		.rdReady1(src1Ready), .rdReady2(src2Ready),
		.allocValid(dispFire && !dispIsStore), .allocRd(dispRd), // stores claim no dest
		.aluWbValid(aluWbValid), .aluWbRd(aluWbRd), .aluWbData(aluWbData),
		.memWbValid(memWbValid), .memWbRd(memWbRd), .memWbData(memWbData)
	);

	reservationStation rs (
		.clk(clk), .rst(rst), .dispFire(dispFire),
		.dispRs1(dispRs1), .dispRs2(dispRs2), .dispRd(dispRd), .dispImm(dispImm),
		.dispAluSrc(dispAluSrc), .dispAluOp(dispAluOp), .dispFu(dispFu),
		.dispIsStore(dispIsStore), .dispRob(allocIdx),
		.src1Data(src1Data), .src2Data(src2Data),
		.src1Ready(src1Ready), .src2Ready(src2Ready), .rsFree(rsFree),
		.aluWbValid(aluWbValid), .aluWbRd(aluWbRd), .aluWbData(aluWbData),
		.memWbValid(memWbValid), .memWbRd(memWbRd), .memWbData(memWbData),
		.aluIssue(aluIssue), .aluIssueEntry(aluIssueEntry),
		.memIssue(memIssue), .memIssueEntry(memIssueEntry)
	);

	reorderBuffer rob (
		.clk(clk), .rst(rst), .dispFire(dispFire),
		.dispRd(dispRd), .dispOldRd(dispOldRd), .dispPc(dispPc), .dispIsStore(dispIsStore),
		.allocIdx(allocIdx), .robFree(robFree),
		.aluWbValid(aluWbValid), .aluWbRob(aluWbRob), .aluWbData(aluWbData),
		.memWbValid(memWbValid), .memWbRob(memWbRob), .memWbData(memWbData),
		.memWbStore(memWbStore), .memWbAddr(memWbAddr), .memWbStoreData(memWbStoreData),
		.retireValid(retireValid), .retirePc(retirePc), .retireDest(retireDest),
		.retireValue(retireValue), .retireOldDest(retireOldDest),
		.retireIsStore(retireIsStore), .storeAddr(storeAddr), .storeData(storeData)
	);

	aluUnit alu (
		.clk(clk), .rst(rst),
		.issue(aluIssue), .issueEntry(aluIssueEntry),
		.wbValid(aluWbValid), .wbRd(aluWbRd), .wbRob(aluWbRob), .wbData(aluWbData)
	);

	memUnit mem (
		.clk(clk), .rst(rst),
		.issue(memIssue), .issueEntry(memIssueEntry),
		.wbValid(memWbValid), .wbRd(memWbRd), .wbRob(memWbRob), .wbData(memWbData),
		.wbStore(memWbStore), .wbAddr(memWbAddr), .wbStoreData(memWbStoreData),
		.storeWrite(retireIsStore), // only set while a store retires
		.storeAddr(storeAddr), .storeData(storeData)
	);

endmodule

`default_nettype wire

// ==== verif/oooCoreTb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "oooConsts.svh"

module oooCoreTb import isaPkg::*; ();

	localparam int CLK_PERIOD = 20;
	localparam int RESET_CYCLES = 10;
	localparam int N_RANDOM = 40; // mixed alu ops
	localparam int N_DIRECTED = 8; // every op with and without imm
	localparam int N_ZERO = 3; // p0 destination and readers
	localparam int N_STORE = 8;
	localparam int N_LOAD = 10;
	localparam int N_CHAIN = 40; // serial chain that backs up the windows
	localparam int TOTAL_INSTR = N_RANDOM + N_DIRECTED + N_ZERO + N_STORE + N_LOAD + N_CHAIN;

	typedef struct packed {
		wordT pc;
		pregT dest;
		pregT oldDest;
		wordT value;
		logic isStore;
		wordT addr;
		wordT data;
	} expT;

	logic clk, rst;
	logic dispValid, dispReady, dispAluSrc, dispIsLoad, dispIsStore;
	wordT dispPc, dispImm;
	pregT dispRd, dispOldRd, dispRs1, dispRs2;
	aluOpT dispAluOp;
	logic retireValid, retireIsStore;
	wordT retirePc, retireValue, storeAddr, storeData;
	pregT retireDest, retireOldDest;

	expT expQ [$]; // expected retires in program order
	expT head;
	wordT regVal [`PREG_COUNT]; // model value of each preg
	wordT memModel [`DMEM_WORDS]; // model data memory
	pregT archMap [8]; // arch reg to preg
	wordT targets [N_STORE]; // store addresses that the loads reuse
	wordT pcNext;
	logic [31:0] lfsr;
	int nextPreg, errors, sentCount, retireCount;
	logic sawFull; // dispReady seen low while holding

	oooCore UUT (
		.clk(clk), .rst(rst),
		.dispValid(dispValid), .dispPc(dispPc), .dispRd(dispRd), .dispOldRd(dispOldRd),
		.dispRs1(dispRs1), .dispRs2(dispRs2), .dispImm(dispImm), .dispAluSrc(dispAluSrc),
		.dispAluOp(dispAluOp), .dispIsLoad(dispIsLoad), .dispIsStore(dispIsStore),
		.dispReady(dispReady),
		.retireValid(retireValid), .retirePc(retirePc), .retireDest(retireDest),
		.retireValue(retireValue), .retireOldDest(retireOldDest),
		.retireIsStore(retireIsStore), .storeAddr(storeAddr), .storeData(storeData)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// fibonacci lfsr with taps 32 22 2 1 and one step per bit taken
	function automatic logic [31:0] nextBits(input int n);
		logic [31:0] r;
		logic fb;
		r = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			r = {r[30:0], fb};
		end
		return r;
	endfunction

	function automatic wordT aluResult(input aluOpT op, input wordT a, input wordT b);
		case (op)
			ALU_ADD: return a + b;
			ALU_SUB: return a - b;
			ALU_OR: return a | b;
			default: return a & b;
		endcase
	endfunction

	task automatic checkWord(input string name, input wordT got, input wordT exp);
		assert (got === exp) else begin
			errors++;
			$display("ERR %0t %s: got %h, expected %h", $time, name, got, exp);
		end
	endtask

	// present one instruction and hold it until taken
	task automatic sendInstr(input pregT rd, input pregT oldRd, input pregT rs1, input pregT rs2,
			input wordT imm, input logic src, input aluOpT op, input logic ld, input logic st);
		@(negedge clk);
		dispValid = 1'b1;
		dispPc = pcNext;
		dispRd = rd;
		dispOldRd = oldRd;
		dispRs1 = rs1;
		dispRs2 = rs2;
		dispImm = imm;
		dispAluSrc = src;
		dispAluOp = op;
		dispIsLoad = ld;
		dispIsStore = st;
		while (!dispReady) begin
			sawFull = 1'b1;
			@(negedge clk);
		end
		pcNext += 4; // taken at the coming rising edge
	endtask

	task automatic genAlu(input aluOpT op, input logic src, input logic [2:0] rd,
			input logic [2:0] rs1, input logic [2:0] rs2, input wordT imm);
		pregT p1, p2, old, dest;
		wordT v;
		expT e;
		p1 = archMap[rs1];
		p2 = archMap[rs2];
		old = archMap[rd];
		v = aluResult(op, regVal[p1], src ? imm : regVal[p2]);
		dest = '0; // r0 stays on p0
		if (rd != 0) begin
			dest = pregT'(nextPreg);
			nextPreg++;
			archMap[rd] = dest;
			regVal[dest] = v;
		end
		e = '0;
		e.pc = pcNext;
		e.dest = dest;
		e.oldDest = old;
		e.value = v; // rob keeps the result even for p0
		expQ.push_back(e);
		sendInstr(dest, old, p1, p2, imm, src, op, 1'b0, 1'b0);
	endtask

	task automatic genStore(input logic [2:0] rs1, input logic [2:0] rs2, input wordT target);
		pregT p1, p2;
		expT e;
		p1 = archMap[rs1];
		p2 = archMap[rs2];
		memModel[target[9:2]] = regVal[p2];
		e = '0;
		e.pc = pcNext;
		e.isStore = 1'b1;
		e.addr = target;
		e.data = regVal[p2];
		expQ.push_back(e);
		sendInstr('0, '0, p1, p2, target - regVal[p1], 1'b1, ALU_ADD, 1'b0, 1'b1);
	endtask

	task automatic genLoad(input logic [2:0] rd, input logic [2:0] rs1, input wordT target);
		pregT p1, old, dest;
		expT e;
		p1 = archMap[rs1];
		old = archMap[rd];
		dest = pregT'(nextPreg);
		nextPreg++;
		archMap[rd] = dest;
		regVal[dest] = memModel[target[9:2]];
		e = '0;
		e.pc = pcNext;
		e.dest = dest;
		e.oldDest = old;
		e.value = regVal[dest];
		expQ.push_back(e);
		sendInstr(dest, old, p1, '0, target - regVal[p1], 1'b1, ALU_ADD, 1'b1, 1'b0);
	endtask

	// stop dispatching and wait until everything sent has retired
	task automatic drain();
		@(negedge clk);
		dispValid = 1'b0;
		while (expQ.size() != 0) @(negedge clk);
	endtask

	// handshakes as the DUT sees them
	always @(posedge clk) begin
		if (!rst && dispValid && dispReady) sentCount++;
	end

	// retire outputs are settled by the falling edge
	always @(negedge clk) begin
		if (!rst && retireValid) begin
			retireCount++;
			assert (expQ.size() != 0) else begin
				errors++;
				$display("%0t: a retire came with no instruction outstanding", $time);
			end
			if (expQ.size() != 0) begin
				head = expQ.pop_front();
				checkWord("retirePc", retirePc, head.pc);
				checkWord("retireDest", wordT'(retireDest), wordT'(head.dest));
				checkWord("retireOldDest", wordT'(retireOldDest), wordT'(head.oldDest));
				checkWord("retireValue", retireValue, head.value);
				checkWord("retireIsStore", wordT'(retireIsStore), wordT'(head.isStore));
				if (head.isStore) begin
					checkWord("storeAddr", storeAddr, head.addr);
					checkWord("storeData", storeData, head.data);
				end
			end
		end
	end

	initial begin
		repeat (RESET_CYCLES + 40 * TOTAL_INSTR) @(posedge clk);
		$display("timeout: the program did not retire within the cycle limit");
		$display("Regression failed");
		$finish;
	end

	initial begin
		aluOpT op;
		logic src;
		logic [2:0] rd, rs1, rs2;
		wordT imm;
		rst = 1'b1;
		dispValid = 1'b0;
		dispPc = '0;
		dispRd = '0;
		dispOldRd = '0;
		dispRs1 = '0;
		dispRs2 = '0;
		dispImm = '0;
		dispAluSrc = 1'b0;
		dispAluOp = ALU_ADD;
		dispIsLoad = 1'b0;
		dispIsStore = 1'b0;
		lfsr = 32'd94661;
		pcNext = 32'h1000;
		nextPreg = 8; // p1..p7 hold the initial arch state
		errors = 0;
		sentCount = 0;
		retireCount = 0;
		sawFull = 1'b0;
		for (int i = 0; i < `PREG_COUNT; i++) regVal[i] = '0;
		for (int i = 0; i < `DMEM_WORDS; i++) memModel[i] = '0;
		for (int i = 0; i < 8; i++) archMap[i] = pregT'(i);
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		checkWord("dispReady", wordT'(dispReady), 32'd1);
		checkWord("retireValid", wordT'(retireValid), 32'd0);

		for (int i = 0; i < N_RANDOM; i++) begin
			op = aluOpT'(nextBits(2));
			src = nextBits(1);
			rd = nextBits(3); // r0 now and then lands on p0
			rs1 = nextBits(3);
			rs2 = nextBits(3);
			imm = nextBits(32);
			genAlu(op, src, rd, rs1, rs2, imm);
		end
		for (int i = 0; i < N_DIRECTED; i++) begin
			imm = nextBits(32);
			genAlu(aluOpT'(i / 2), i[0], 3'd2, 3'd2, 3'd3, imm); // r2 feeds itself
		end
		genAlu(ALU_ADD, 1'b1, 3'd0, 3'd4, 3'd0, 32'h1234_5678); // result dropped on p0
		genAlu(ALU_OR, 1'b0, 3'd5, 3'd0, 3'd6, '0);
		genAlu(ALU_ADD, 1'b0, 3'd6, 3'd0, 3'd0, '0);

		for (int i = 0; i < N_STORE; i++) begin
			targets[i] = nextBits(8) << 2;
			rs1 = nextBits(3);
			rs2 = nextBits(3);
			genStore(rs1, rs2, targets[i]);
		end
		drain(); // without disambiguation the stores must reach memory first
		for (int i = 0; i < N_LOAD; i++) begin
			rd = nextBits(3);
			rs1 = nextBits(3);
			if (rd == 0) rd = 3'd7;
			imm = (i < N_STORE) ? targets[i] : (nextBits(8) << 2);
			genLoad(rd, rs1, imm);
		end

		for (int i = 0; i < N_CHAIN; i++) begin
			op = aluOpT'(nextBits(2));
			src = nextBits(1);
			imm = nextBits(32);
			genAlu(op, src, 3'd1, 3'd1, 3'd4, imm); // each waits on the one before
		end
		drain();

		assert (retireCount == sentCount) else begin
			errors++;
			$display("%0d instructions sent but %0d retired", sentCount, retireCount);
		end
		assert (sawFull) else begin
			errors++;
			$display("dispReady never fell, the windows were never full");
		end
		$display("sent %0d, retired %0d, errors %0d", sentCount, retireCount, errors);
		if (errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+src
src/isaPkg.sv
src/windowPkg.sv
src/physRegFile.sv
src/reservationStation.sv
src/reorderBuffer.sv
src/aluUnit.sv
src/memUnit.sv
src/oooCore.sv
verif/oooCoreTb.sv
